// ==== logic/ads5296_pkg.sv ====
package ads5296_pkg;

  // adc geometry
  localparam int NUM_UNITS   = 4;
  localparam int NUM_FCLKS   = 1;
  localparam int NUM_DLY     = 4*2*NUM_UNITS + NUM_FCLKS + 1;  // data lanes, fclk, sync_out
  localparam int NUM_LO_DLY  = 4*2*NUM_UNITS;                  // data lanes only
  localparam int NUM_HI_DLY  = NUM_DLY - NUM_LO_DLY;           // fclk + sync bit
  localparam int DLY_VAL_W   = 9;                              // idelaye3 cntvaluein
  localparam int NUM_BITSLIP = 4*NUM_UNITS;

  // frame clock monitor
  localparam int FRAME_LANES = 4;
  localparam int FRAME_W     = 8;
  localparam logic [FRAME_W-1:0] FRAME_PATTERN = 8'hF0;  // 1-wire 8x fclk word
  localparam int CNT_W       = 32;

  // wishbone
  localparam int WB_ADR_W  = 32;
  localparam int WB_DAT_W  = 32;
  localparam int WB_SEL_W  = WB_DAT_W / 8;
  localparam int REG_IDX_W = 5;  // word index from adr[6:2]

  // register map, word indices
  localparam logic [REG_IDX_W-1:0] REG_DLY_LOAD_LO   = 5'd0;
  localparam logic [REG_IDX_W-1:0] REG_DLY_LOAD_HI   = 5'd1;
  localparam logic [REG_IDX_W-1:0] REG_DLY_RST_LO    = 5'd2;
  localparam logic [REG_IDX_W-1:0] REG_DLY_RST_HI    = 5'd3;
  localparam logic [REG_IDX_W-1:0] REG_DLY_EN_VTC_LO = 5'd4;
  localparam logic [REG_IDX_W-1:0] REG_DLY_EN_VTC_HI = 5'd5;
  localparam logic [REG_IDX_W-1:0] REG_DLY_VAL       = 5'd6;
  localparam logic [REG_IDX_W-1:0] REG_FCLK_ERR_CNT  = 5'd7;
  localparam logic [REG_IDX_W-1:0] REG_ISERDES_RST   = 5'd8;
  localparam logic [REG_IDX_W-1:0] REG_MMCM          = 5'd9;
  localparam logic [REG_IDX_W-1:0] REG_LCLK_CNT      = 5'd10;
  localparam logic [REG_IDX_W-1:0] REG_FCLK0_CNT     = 5'd11;
  localparam logic [REG_IDX_W-1:0] REG_FCLK1_CNT     = 5'd12;
  localparam logic [REG_IDX_W-1:0] REG_FCLK2_CNT     = 5'd13;
  localparam logic [REG_IDX_W-1:0] REG_FCLK3_CNT     = 5'd14;
  localparam logic [REG_IDX_W-1:0] REG_BITSLIP       = 5'd15;
  localparam logic [REG_IDX_W-1:0] REG_SNAPSHOT      = 5'd16;
  localparam logic [REG_IDX_W-1:0] REG_VERSION       = 5'd17;

  localparam logic                IS_MASTER = 1'b1;
  localparam logic [WB_DAT_W-1:0] VERSION   = 32'h0001_0002;

  // delay load sequencing
  localparam int SEQ_SETUP = 2;  // en_vtc low before load
  localparam int SEQ_HOLD  = 2;  // en_vtc low after load
  localparam int SEQ_CNT_W = $clog2(SEQ_SETUP > SEQ_HOLD ? SEQ_SETUP : SEQ_HOLD) + 1;

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_SETUP = 2'd1;
  localparam logic [1:0] ST_LOAD  = 2'd2;
  localparam logic [1:0] ST_HOLD  = 2'd3;

endpackage

// ==== logic/adc_mon_if.sv ====
`timescale 1ns/100ps

interface adc_mon_if;
  import ads5296_pkg::*;

  logic [CNT_W-1:0]                  lclk_cnt;      // valid frames seen
  logic [FRAME_LANES-1:0][CNT_W-1:0] fclk_cnt;      // per lane pattern hits
  logic [CNT_W-1:0]                  fclk_err_cnt;  // frames with any bad lane
  logic                              cnt_clr;       // one cycle, from reg 7 write

  // frame monitor side
  modport mon (
    output lclk_cnt, fclk_cnt, fclk_err_cnt,
    input  cnt_clr
  );

  // register block side
  modport regs (
    input  lclk_cnt, fclk_cnt, fclk_err_cnt,
    output cnt_clr
  );

endinterface

// ==== logic/adc_dly_if.sv ====
`timescale 1ns/100ps

interface adc_dly_if;
  import ads5296_pkg::*;

  logic                   load_req;     // pulse on reg 0/1 write
  logic [NUM_DLY-1:0]     load_mask;    // lanes to load
  logic [NUM_DLY-1:0]     en_vtc_base;  // en_vtc level when idle
  logic [DLY_VAL_W-1:0]   dly_val;      // tap value
  logic                   slip_req;     // pulse on reg 15 write
  logic [NUM_BITSLIP-1:0] slip_mask;
  logic                   busy;         // sequence in flight

  // register block drives requests, reads busy
  modport regs (
    output load_req, load_mask, en_vtc_base, dly_val,
    output slip_req, slip_mask,
    input  busy
  );

  // sequencer side
  modport seq (
    input  load_req, load_mask, en_vtc_base, dly_val,
    input  slip_req, slip_mask,
    output busy
  );

endinterface

// ==== logic/frame_monitor.sv ====
`timescale 1ns/100ps

module frame_monitor (
  input  logic wb_clk_i,
  input  logic wb_rst_i,
  adc_mon_if.mon mon,
  input  logic frame_vld_i,
  input  logic [ads5296_pkg::FRAME_LANES-1:0][ads5296_pkg::FRAME_W-1:0] frame_word_i
);
  import ads5296_pkg::*;

  logic [FRAME_LANES-1:0]            lane_ok;   // lane matches pattern
  logic                              frame_bad; // at least one lane off
  logic [CNT_W-1:0]                  lclk_q;
  logic [FRAME_LANES-1:0][CNT_W-1:0] fclk_q;
  logic [CNT_W-1:0]                  err_q;

  // per lane compare
  always_comb begin
    for (int l = 0; l < FRAME_LANES; l++) begin
      lane_ok[l] = (frame_word_i[l] == FRAME_PATTERN);
    end
  end

  assign frame_bad = ~&lane_ok;

  // counters, saturating
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || mon.cnt_clr) begin  // clear beats a coincident frame
      lclk_q <= '0;
      fclk_q <= '0;
      err_q  <= '0;
    end else if (frame_vld_i) begin
      if (lclk_q != '1)
        lclk_q <= lclk_q + 1'b1;
      for (int l = 0; l < FRAME_LANES; l++) begin
        if (lane_ok[l] && fclk_q[l] != '1)
          fclk_q[l] <= fclk_q[l] + 1'b1;
      end
      if (frame_bad && err_q != '1)
        err_q <= err_q + 1'b1;  // one per frame, not per lane
    end
  end

  assign mon.lclk_cnt     = lclk_q;
  assign mon.fclk_cnt     = fclk_q;
  assign mon.fclk_err_cnt = err_q;

  // counts only move up unless the register block clears them
  a_cnt_monotonic: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    !mon.cnt_clr |=> (lclk_q >= $past(lclk_q)) && (err_q >= $past(err_q))
  );

  for (genvar g = 0; g < FRAME_LANES; g++) begin : g_lane_chk
    a_lane_monotonic: assert property (
      @(posedge wb_clk_i) disable iff (wb_rst_i)
      !mon.cnt_clr |=> fclk_q[g] >= $past(fclk_q[g])
    );
  end

endmodule

// ==== logic/wb_ads5296_regs.sv ====
`timescale 1ns/100ps

module wb_ads5296_regs (
  input  logic wb_clk_i,
  input  logic wb_rst_i,
  input  logic [ads5296_pkg::WB_ADR_W-1:0] wb_adr_i,
  input  logic [ads5296_pkg::WB_DAT_W-1:0] wb_dat_i,
  input  logic [ads5296_pkg::WB_SEL_W-1:0] wb_sel_i,
  input  logic wb_we_i,
  input  logic wb_cyc_i,
  input  logic wb_stb_i,
  output logic [ads5296_pkg::WB_DAT_W-1:0] wb_dat_o,
  output logic wb_ack_o,
  input  logic mmcm_locked_i,
  output logic [ads5296_pkg::NUM_DLY-1:0] delay_rst_o,
  output logic iserdes_rst_o,
  output logic mmcm_rst_o,
  output logic mmcm_clksel_o,
  output logic snapshot_trigger_o,
  adc_mon_if.regs mon,
  adc_dly_if.regs dly
);
  import ads5296_pkg::*;

  logic                   wb_ack;
  logic                   acc;        // new strobe, not yet acked
  logic [REG_IDX_W-1:0]   reg_idx;
  logic [WB_DAT_W-1:0]    rd_word;    // addressed register, zero filled
  logic [WB_DAT_W-1:0]    sel_mask;   // byte lanes from wb_sel_i
  logic [WB_DAT_W-1:0]    wr_word;    // merged write data
  logic [WB_DAT_W-1:0]    rd_q;

  logic [NUM_DLY-1:0]     delay_load_reg;
  logic [NUM_DLY-1:0]     delay_rst_reg;
  logic [NUM_DLY-1:0]     delay_en_vtc_reg;
  logic [DLY_VAL_W-1:0]   delay_val_reg;
  logic [NUM_BITSLIP-1:0] bitslip_reg;
  logic                   iserdes_rst_reg;
  logic                   mmcm_rst_reg;
  logic                   mmcm_clksel_reg;
  logic                   snapshot_reg;
  logic                   load_req_q;
  logic                   slip_req_q;
  logic                   cnt_clr_q;

  assign acc     = wb_stb_i & wb_cyc_i & ~wb_ack;
  assign reg_idx = wb_adr_i[6:2];

  always_comb begin
    for (int b = 0; b < WB_SEL_W; b++) begin
      sel_mask[8*b +: 8] = {8{wb_sel_i[b]}};
    end
  end

  // readback mux
  always_comb begin
    rd_word = '0;
    case (reg_idx)
      REG_DLY_LOAD_LO:   rd_word[NUM_LO_DLY-1:0] = delay_load_reg[NUM_LO_DLY-1:0];
      REG_DLY_LOAD_HI:   rd_word[NUM_HI_DLY-1:0] = delay_load_reg[NUM_DLY-1:NUM_LO_DLY];
      REG_DLY_RST_LO:    rd_word[NUM_LO_DLY-1:0] = delay_rst_reg[NUM_LO_DLY-1:0];
      REG_DLY_RST_HI:    rd_word[NUM_HI_DLY-1:0] = delay_rst_reg[NUM_DLY-1:NUM_LO_DLY];
      REG_DLY_EN_VTC_LO: rd_word[NUM_LO_DLY-1:0] = delay_en_vtc_reg[NUM_LO_DLY-1:0];
      REG_DLY_EN_VTC_HI: rd_word[NUM_HI_DLY-1:0] = delay_en_vtc_reg[NUM_DLY-1:NUM_LO_DLY];
      REG_DLY_VAL: begin
        rd_word[DLY_VAL_W-1:0] = delay_val_reg;
        rd_word[WB_DAT_W-1]    = dly.busy;  // sequencer in flight
      end
      REG_FCLK_ERR_CNT:  rd_word[CNT_W-1:0] = mon.fclk_err_cnt;
      REG_ISERDES_RST:   rd_word[0] = iserdes_rst_reg;
      REG_MMCM:          rd_word = {7'b0, IS_MASTER, 7'b0, mmcm_locked_i,
                                    7'b0, mmcm_clksel_reg, 7'b0, mmcm_rst_reg};
      REG_LCLK_CNT:      rd_word[CNT_W-1:0] = mon.lclk_cnt;
      REG_FCLK0_CNT:     rd_word[CNT_W-1:0] = mon.fclk_cnt[0];
      REG_FCLK1_CNT:     rd_word[CNT_W-1:0] = mon.fclk_cnt[1];
      REG_FCLK2_CNT:     rd_word[CNT_W-1:0] = mon.fclk_cnt[2];
      REG_FCLK3_CNT:     rd_word[CNT_W-1:0] = mon.fclk_cnt[3];
      REG_BITSLIP:       rd_word[NUM_BITSLIP-1:0] = bitslip_reg;
      REG_SNAPSHOT:      rd_word[0] = snapshot_reg;
      REG_VERSION:       rd_word = VERSION;
      default:           rd_word = '0;  // unmapped reads zero
    endcase
  end

  // unselected bytes keep their current value
  assign wr_word = (rd_word & ~sel_mask) | (wb_dat_i & sel_mask);

  always_ff @(posedge wb_clk_i) begin
    wb_ack     <= 1'b0;  // strobes
    load_req_q <= 1'b0;
    slip_req_q <= 1'b0;
    cnt_clr_q  <= 1'b0;
    if (wb_rst_i) begin
      delay_load_reg   <= '0;
      delay_rst_reg    <= '0;
      delay_en_vtc_reg <= '0;
      delay_val_reg    <= '0;
      bitslip_reg      <= '0;
      iserdes_rst_reg  <= 1'b0;
      mmcm_rst_reg     <= 1'b0;
      mmcm_clksel_reg  <= 1'b0;
      snapshot_reg     <= 1'b0;
    end else if (acc) begin
      wb_ack <= 1'b1;
      if (wb_we_i) begin
        case (reg_idx)
          REG_DLY_LOAD_LO: begin
            delay_load_reg[NUM_LO_DLY-1:0] <= wr_word[NUM_LO_DLY-1:0];
            load_req_q <= 1'b1;
          end
          REG_DLY_LOAD_HI: begin
            delay_load_reg[NUM_DLY-1:NUM_LO_DLY] <= wr_word[NUM_HI_DLY-1:0];
            load_req_q <= 1'b1;
          end
          REG_DLY_RST_LO:    delay_rst_reg[NUM_LO_DLY-1:0] <= wr_word[NUM_LO_DLY-1:0];
          REG_DLY_RST_HI:    delay_rst_reg[NUM_DLY-1:NUM_LO_DLY] <= wr_word[NUM_HI_DLY-1:0];
          REG_DLY_EN_VTC_LO: delay_en_vtc_reg[NUM_LO_DLY-1:0] <= wr_word[NUM_LO_DLY-1:0];
          REG_DLY_EN_VTC_HI: delay_en_vtc_reg[NUM_DLY-1:NUM_LO_DLY] <= wr_word[NUM_HI_DLY-1:0];
          REG_DLY_VAL:       delay_val_reg <= wr_word[DLY_VAL_W-1:0];
          REG_FCLK_ERR_CNT:  cnt_clr_q <= 1'b1;  // any write clears all counters
          REG_ISERDES_RST:   iserdes_rst_reg <= wr_word[0];
          REG_MMCM: begin
            mmcm_rst_reg    <= wr_word[0];
            mmcm_clksel_reg <= wr_word[8];
          end
          REG_BITSLIP: begin
            bitslip_reg <= wr_word[NUM_BITSLIP-1:0];
            slip_req_q  <= 1'b1;
          end
          REG_SNAPSHOT:      snapshot_reg <= wr_word[0];
          default: begin
            // counters and version are read only
          end
        endcase
      end
    end
  end

  // read data, only visible with ack
  always_ff @(posedge wb_clk_i) begin
    if (acc)
      rd_q <= wb_we_i ? '0 : rd_word;
  end

  assign wb_ack_o = wb_ack;
  assign wb_dat_o = wb_ack ? rd_q : '0;

  assign delay_rst_o        = delay_rst_reg;
  assign iserdes_rst_o      = iserdes_rst_reg;
  assign mmcm_rst_o         = mmcm_rst_reg;
  assign mmcm_clksel_o      = mmcm_clksel_reg;
  assign snapshot_trigger_o = snapshot_reg;

  assign mon.cnt_clr   = cnt_clr_q;
  assign dly.load_req  = load_req_q;
  assign dly.load_mask = delay_load_reg;
  assign dly.en_vtc_base = delay_en_vtc_reg;
  assign dly.dly_val   = delay_val_reg;
  assign dly.slip_req  = slip_req_q;
  assign dly.slip_mask = bitslip_reg;

  // single cycle ack per access
  a_ack_single: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_o |=> !wb_ack_o
  );

endmodule

// ==== logic/idelay_load_seq.sv ====
`timescale 1ns/100ps

module idelay_load_seq (
  input  logic wb_clk_i,
  input  logic wb_rst_i,
  adc_dly_if.seq dly,
  output logic [ads5296_pkg::NUM_DLY-1:0] delay_load_o,
  output logic [ads5296_pkg::NUM_DLY-1:0] delay_en_vtc_o,
  output logic [ads5296_pkg::DLY_VAL_W-1:0] delay_val_o,
  output logic [ads5296_pkg::NUM_BITSLIP-1:0] bitslip_o
);
  import ads5296_pkg::*;

  logic [1:0]           state;
  logic [SEQ_CNT_W-1:0] cnt;      // cycles spent in setup or hold
  logic                 pend;     // load_req seen while busy
  logic                 start;
  logic                 busy;
  logic [NUM_DLY-1:0]   mask_q;   // lanes of the running sequence
  logic [DLY_VAL_W-1:0] val_q;    // tap value frozen for the sequence

  assign start = (state == ST_IDLE) && (dly.load_req || pend);
  assign busy  = (state != ST_IDLE);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state     <= ST_IDLE;
      cnt       <= '0;
      pend      <= 1'b0;
      bitslip_o <= '0;
    end else begin
      bitslip_o <= dly.slip_req ? dly.slip_mask : '0;  // one cycle, ignores busy

      if (state == ST_IDLE)
        pend <= 1'b0;       // consumed by start below
      else if (dly.load_req)
        pend <= 1'b1;       // several requests merge into one

      case (state)
        ST_IDLE: begin
          if (start) begin
            state <= ST_SETUP;
            cnt   <= '0;
          end
        end
        ST_SETUP: begin
          if (cnt == SEQ_CNT_W'(SEQ_SETUP - 1)) begin
            state <= ST_LOAD;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        ST_LOAD: state <= ST_HOLD;  // single load cycle
        ST_HOLD: begin
          if (cnt == SEQ_CNT_W'(SEQ_HOLD - 1))
            state <= ST_IDLE;  // en_vtc restored next cycle
          else
            cnt <= cnt + 1'b1;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // capture mask and tap at sequence start
  always_ff @(posedge wb_clk_i) begin
    if (start) begin
      mask_q <= dly.load_mask;
      val_q  <= dly.dly_val;
    end
  end

  assign dly.busy       = busy;
  assign delay_load_o   = (state == ST_LOAD) ? mask_q : '0;
  assign delay_en_vtc_o = busy ? (dly.en_vtc_base & ~mask_q) : dly.en_vtc_base;
  assign delay_val_o    = busy ? val_q : dly.dly_val;

  // vtc stays off on loaded lanes through the load and the cycle after
  a_vtc_off_on_load: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    (|delay_load_o) |-> ((delay_en_vtc_o & delay_load_o) == '0)
      ##1 ((delay_en_vtc_o & $past(delay_load_o)) == '0)
  );

endmodule

// ==== logic/ads5296_ctrl_top.sv ====
`timescale 1ns/100ps

module ads5296_ctrl_top (
  input  logic wb_clk_i,
  input  logic wb_rst_i,
  input  logic [ads5296_pkg::WB_ADR_W-1:0] wb_adr_i,
  input  logic [ads5296_pkg::WB_DAT_W-1:0] wb_dat_i,
  input  logic [ads5296_pkg::WB_SEL_W-1:0] wb_sel_i,
  input  logic wb_we_i,
  input  logic wb_cyc_i,
  input  logic wb_stb_i,
  output logic [ads5296_pkg::WB_DAT_W-1:0] wb_dat_o,
  output logic wb_ack_o,
  input  logic mmcm_locked_i,
  input  logic frame_vld_i,
  input  logic [ads5296_pkg::FRAME_LANES-1:0][ads5296_pkg::FRAME_W-1:0] frame_word_i,
  output logic [ads5296_pkg::NUM_DLY-1:0] delay_rst_o,
  output logic iserdes_rst_o,
  output logic mmcm_rst_o,
  output logic mmcm_clksel_o,
  output logic snapshot_trigger_o,
  output logic [ads5296_pkg::NUM_DLY-1:0] delay_load_o,
  output logic [ads5296_pkg::NUM_DLY-1:0] delay_en_vtc_o,
  output logic [ads5296_pkg::DLY_VAL_W-1:0] delay_val_o,
  output logic [ads5296_pkg::NUM_BITSLIP-1:0] bitslip_o
);

  adc_mon_if mon_if ();  // counters up, clear down
  adc_dly_if dly_if ();  // load and slip requests

  frame_monitor u_frame_monitor (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .mon          (mon_if.mon),
    .frame_vld_i  (frame_vld_i),
    .frame_word_i (frame_word_i)
  );

  wb_ads5296_regs u_regs (
    .wb_clk_i           (wb_clk_i),
    .wb_rst_i           (wb_rst_i),
    .wb_adr_i           (wb_adr_i),
    .wb_dat_i           (wb_dat_i),
    .wb_sel_i           (wb_sel_i),
    .wb_we_i            (wb_we_i),
    .wb_cyc_i           (wb_cyc_i),
    .wb_stb_i           (wb_stb_i),
    .wb_dat_o           (wb_dat_o),
    .wb_ack_o           (wb_ack_o),
    .mmcm_locked_i      (mmcm_locked_i),
    .delay_rst_o        (delay_rst_o),
    .iserdes_rst_o      (iserdes_rst_o),
    .mmcm_rst_o         (mmcm_rst_o),
    .mmcm_clksel_o      (mmcm_clksel_o),
    .snapshot_trigger_o (snapshot_trigger_o),
    .mon                (mon_if.regs),
    .dly                (dly_if.regs)
  );

  idelay_load_seq u_load_seq (
    .wb_clk_i       (wb_clk_i),
    .wb_rst_i       (wb_rst_i),
    .dly            (dly_if.seq),
    .delay_load_o   (delay_load_o),
    .delay_en_vtc_o (delay_en_vtc_o),
    .delay_val_o    (delay_val_o),
    .bitslip_o      (bitslip_o)
  );

endmodule

// ==== testbench/tb_ads5296_ctrl.sv ====
`timescale 1ns/100ps

module tb_ads5296_ctrl;
  import ads5296_pkg::*;

  localparam int TIMEOUT_CYCLES = 4000;  // whole run needs a few hundred cycles

  logic                                wb_clk_i;
  logic                                wb_rst_i;
  logic [WB_ADR_W-1:0]                 wb_adr_i;
  logic [WB_DAT_W-1:0]                 wb_dat_i;
  logic [WB_SEL_W-1:0]                 wb_sel_i;
  logic                                wb_we_i, wb_cyc_i, wb_stb_i;
  logic [WB_DAT_W-1:0]                 wb_dat_o;
  logic                                wb_ack_o;
  logic                                mmcm_locked_i;
  logic                                frame_vld_i;
  logic [FRAME_LANES-1:0][FRAME_W-1:0] frame_word_i;
  logic [NUM_DLY-1:0]                  delay_rst_o, delay_load_o, delay_en_vtc_o;
  logic                                iserdes_rst_o, mmcm_rst_o, mmcm_clksel_o;
  logic                                snapshot_trigger_o;
  logic [DLY_VAL_W-1:0]                delay_val_o;
  logic [NUM_BITSLIP-1:0]              bitslip_o;

  int                   errors, checks, cycles;
  int                   load_pulses, slip_pulses;  // seen at negedge
  int                   exp_lclk, exp_err;         // own frame tally
  int                   exp_fclk [FRAME_LANES];
  logic [31:0]          wdat [0:17];               // last data written per register
  logic [31:0]          rd;
  logic [NUM_DLY-1:0]   mask, vtc_exp, last_load;
  logic [DLY_VAL_W-1:0] last_tap;                  // tap on the delay outputs at load
  logic [DLY_VAL_W-1:0] tap_new;                   // tap written while busy

  ads5296_ctrl_top UUT (.*);

  initial begin
    wb_clk_i = 1'b0;
    forever #2 wb_clk_i = ~wb_clk_i;  // 4 ns
  end

  always @(posedge wb_clk_i) begin
    cycles++;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("timeout: run stopped after %0d cycles without finishing", cycles);
      $display("Regression failed");
      $finish;
    end
  end

  // pulse counters sampled mid cycle
  always @(negedge wb_clk_i) begin
    if (!wb_rst_i) begin
      if (|delay_load_o) begin
        load_pulses++;
        last_load = delay_load_o;
        last_tap  = delay_val_o;
      end
      if (|bitslip_o)
        slip_pulses++;
    end
  end

  // bus protocol
  ack_next: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (wb_cyc_i && wb_stb_i && !wb_ack_o) |=> wb_ack_o)
    else begin
      errors++;
      $display("[FAIL] ack_next: expected ack 1, actual 0");
    end
  ack_once: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_o |=> !wb_ack_o)
    else begin
      errors++;
      $display("[FAIL] ack_once: expected ack 0, actual 1");
    end
  dat_idle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    !wb_ack_o |-> wb_dat_o == '0)
    else begin
      errors++;
      $display("[FAIL] dat_idle: expected 0, actual %h", $sampled(wb_dat_o));
    end

  task automatic expect_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (act === exp)
      else begin
        errors++;
        $display("[FAIL] %s: expected %0h, actual %0h", name, exp, act);
      end
  endtask

  // single-beat access with read data sampled at ack
  task automatic access_reg(input logic [REG_IDX_W-1:0] idx, input logic we,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    @(posedge wb_clk_i);
    #1;
    wb_adr_i = {25'b0, idx, 2'b00};
    wb_dat_i = wdata;
    wb_sel_i = '1;
    wb_we_i  = we;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    waited   = 0;
    do begin
      @(posedge wb_clk_i);
      #1;
      waited++;
    end while (!wb_ack_o && waited < 16);
    if (!wb_ack_o) begin
      errors++;
      $display("error: no ack for register %0d within 16 cycles", idx);
    end
    expect_eq($sformatf("ack delay reg %0d", idx), 1, waited);
    rdata    = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  function automatic logic [31:0] field_mask(input int idx);
    case (idx)
      0, 2, 4: return 32'hffff_ffff;                   // data lanes
      1, 3, 5: return (32'd1 << NUM_HI_DLY) - 1;       // fclk and sync
      6:       return (32'd1 << DLY_VAL_W) - 1;
      8, 16:   return 32'h1;
      9:       return 32'h101;                         // mmcm rst, clksel
      15:      return (32'd1 << NUM_BITSLIP) - 1;
      default: return 32'h0;                           // counters, version
    endcase
  endfunction

  function automatic logic [31:0] expected_read(input int idx, input logic [31:0] wdata);
    logic [31:0] exp;
    exp = wdata & field_mask(idx);
    if (idx == 9) begin
      exp[24] = IS_MASTER;
      exp[16] = mmcm_locked_i;
    end
    if (idx == 17)
      exp = VERSION;
    return exp;
  endfunction

  task automatic wait_idle();
    logic [31:0] st;
    int          polls;
    polls = 0;
    do begin
      access_reg(REG_DLY_VAL, 1'b0, '0, st);
      polls++;
    end while (st[31] && polls < 20);
    if (st[31]) begin
      errors++;
      $display("error: delay sequencer still busy after %0d polls", polls);
    end
  endtask

  task automatic wait_loads(input int n);
    int waited;
    waited = 0;
    while (load_pulses < n && waited < 100) begin
      @(posedge wb_clk_i);
      waited++;
    end
    if (load_pulses < n) begin
      errors++;
      $display("error: only %0d of %0d delay load pulses seen", load_pulses, n);
    end
  endtask

  // random good and bad frames with idle gaps and own tally
  task automatic drive_frames(input int n);
    logic [FRAME_LANES-1:0][FRAME_W-1:0] w;
    logic                                vld, bad;
    for (int i = 0; i < n; i++) begin
      vld = ($urandom % 4) != 0;
      bad = 1'b0;
      for (int l = 0; l < FRAME_LANES; l++) begin
        w[l] = FRAME_PATTERN;
        if ($urandom % 4 == 0)
          w[l] = FRAME_PATTERN ^ FRAME_W'(1 + $urandom % 255);  // always a miss
      end
      @(posedge wb_clk_i);
      #1;
      frame_vld_i  = vld;
      frame_word_i = w;
      if (vld) begin
        exp_lclk++;
        for (int l = 0; l < FRAME_LANES; l++) begin
          if (w[l] == FRAME_PATTERN)
            exp_fclk[l]++;
          else
            bad = 1'b1;
        end
        if (bad)
          exp_err++;
      end
    end
    @(posedge wb_clk_i);
    #1;
    frame_vld_i = 1'b0;
  endtask

  initial begin
    void'($urandom(32'h936e));
    wb_rst_i      = 1'b1;
    wb_adr_i      = '0;
    wb_dat_i      = '0;
    wb_sel_i      = '0;
    wb_we_i       = 1'b0;
    wb_cyc_i      = 1'b0;
    wb_stb_i      = 1'b0;
    mmcm_locked_i = 1'b1;
    frame_vld_i   = 1'b0;
    frame_word_i  = '0;
    repeat (5) @(posedge wb_clk_i);
    #1;
    wb_rst_i = 1'b0;

    // reset values
    for (int i = 0; i <= 17; i++) begin
      access_reg(REG_IDX_W'(i), 1'b0, '0, rd);
      expect_eq($sformatf("reset reg %0d", i), expected_read(i, '0), rd);
    end
    mmcm_locked_i = 1'b0;  // reg 9 readback sees the input low

    // random writes, masked readback and level outputs
    for (int i = 0; i <= 17; i++) begin
      wdat[i] = $urandom();
      if (field_mask(i) != 0)
        access_reg(REG_IDX_W'(i), 1'b1, wdat[i], rd);
    end
    wait_idle();
    for (int i = 0; i <= 17; i++) begin
      if (field_mask(i) != 0) begin
        access_reg(REG_IDX_W'(i), 1'b0, '0, rd);
        expect_eq($sformatf("readback reg %0d", i), expected_read(i, wdat[i]), rd);
      end
    end
    expect_eq("delay_rst_o", {wdat[3][NUM_HI_DLY-1:0], wdat[2]}, delay_rst_o);
    expect_eq("delay_en_vtc_o idle", {wdat[5][NUM_HI_DLY-1:0], wdat[4]}, delay_en_vtc_o);
    expect_eq("delay_val_o idle", wdat[6][DLY_VAL_W-1:0], delay_val_o);
    expect_eq("iserdes_rst_o", wdat[8][0], iserdes_rst_o);
    expect_eq("mmcm_rst_o", wdat[9][0], mmcm_rst_o);
    expect_eq("mmcm_clksel_o", wdat[9][8], mmcm_clksel_o);
    expect_eq("snapshot_trigger_o", wdat[16][0], snapshot_trigger_o);

    // single load sequence with all en_vtc lanes on
    access_reg(REG_DLY_EN_VTC_LO, 1'b1, '1, rd);
    access_reg(REG_DLY_EN_VTC_HI, 1'b1, '1, rd);
    wdat[6] = $urandom();
    access_reg(REG_DLY_VAL, 1'b1, wdat[6], rd);
    wait_idle();
    wdat[0]     = $urandom() | 32'h1;  // at least one lane loads
    mask        = {wdat[1][NUM_HI_DLY-1:0], wdat[0]};
    load_pulses = 0;
    access_reg(REG_DLY_LOAD_LO, 1'b1, wdat[0], rd);
    for (int k = 1; k <= SEQ_SETUP + SEQ_HOLD + 2; k++) begin
      @(posedge wb_clk_i);
      #1;
      vtc_exp = (k <= SEQ_SETUP + SEQ_HOLD + 1) ? ~mask : '1;  // restore after hold
      expect_eq($sformatf("load pulse cycle %0d", k),
                (k == SEQ_SETUP + 1) ? mask : '0, delay_load_o);
      expect_eq($sformatf("en_vtc cycle %0d", k), vtc_exp, delay_en_vtc_o);
      expect_eq($sformatf("tap cycle %0d", k), wdat[6][DLY_VAL_W-1:0], delay_val_o);
    end
    expect_eq("single load pulse", 1, load_pulses);

    // busy readback, then two writes during busy merge into one more sequence
    load_pulses = 0;
    wdat[0]     = $urandom() | 32'h1;
    access_reg(REG_DLY_LOAD_LO, 1'b1, wdat[0], rd);
    access_reg(REG_DLY_VAL, 1'b0, '0, rd);
    expect_eq("busy in reg 6", 1, rd[31]);
    wdat[1] = $urandom();
    access_reg(REG_DLY_LOAD_HI, 1'b1, wdat[1], rd);
    wdat[0] = $urandom() | 32'h1;
    access_reg(REG_DLY_LOAD_LO, 1'b1, wdat[0], rd);
    wait_loads(2);
    wait_idle();
    repeat (4 * (SEQ_SETUP + SEQ_HOLD + 1)) @(posedge wb_clk_i);  // no third sequence
    expect_eq("merged load pulses", 2, load_pulses);
    expect_eq("merged load mask", {wdat[1][NUM_HI_DLY-1:0], wdat[0]}, last_load);

    // new tap written during the setup phase waits for the sequence to end
    load_pulses = 0;
    wdat[0]     = $urandom() | 32'h1;
    tap_new     = ~wdat[6][DLY_VAL_W-1:0];
    access_reg(REG_DLY_LOAD_LO, 1'b1, wdat[0], rd);
    access_reg(REG_DLY_VAL, 1'b1, 32'(tap_new), rd);
    wait_loads(1);
    expect_eq("tap held at load", wdat[6][DLY_VAL_W-1:0], last_tap);
    wait_idle();
    expect_eq("tap after load", tap_new, delay_val_o);

    // bitslip pulse one cycle after the write
    slip_pulses = 0;
    wdat[15]    = $urandom() | 32'h1;
    access_reg(REG_BITSLIP, 1'b1, wdat[15], rd);
    expect_eq("bitslip before pulse", 0, bitslip_o);
    @(posedge wb_clk_i);
    #1;
    expect_eq("bitslip pulse", wdat[15][NUM_BITSLIP-1:0], bitslip_o);
    @(posedge wb_clk_i);
    #1;
    expect_eq("bitslip after pulse", 0, bitslip_o);
    expect_eq("bitslip pulse count", 1, slip_pulses);

    // frame counters against own tally, then clear
    drive_frames(48);
    access_reg(REG_LCLK_CNT, 1'b0, '0, rd);
    expect_eq("lclk count", exp_lclk, rd);
    for (int l = 0; l < FRAME_LANES; l++) begin
      access_reg(REG_FCLK0_CNT + REG_IDX_W'(l), 1'b0, '0, rd);
      expect_eq($sformatf("fclk%0d count", l), exp_fclk[l], rd);
    end
    access_reg(REG_FCLK_ERR_CNT, 1'b0, '0, rd);
    expect_eq("frame error count", exp_err, rd);
    access_reg(REG_FCLK_ERR_CNT, 1'b1, $urandom(), rd);  // any data clears
    for (int i = 7; i <= 14; i++) begin
      if (i < 8 || i > 9) begin
        access_reg(REG_IDX_W'(i), 1'b0, '0, rd);
        expect_eq($sformatf("cleared reg %0d", i), 0, rd);
      end
    end

    $display("checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

// ==== ads5296_ctrl_top.f ====
logic/ads5296_pkg.sv
logic/adc_mon_if.sv
logic/adc_dly_if.sv
logic/frame_monitor.sv
logic/wb_ads5296_regs.sv
logic/idelay_load_seq.sv
logic/ads5296_ctrl_top.sv
testbench/tb_ads5296_ctrl.sv

// ==== Bender.yml ====
package:
  name: ads5296_ctrl

sources:
  - logic/ads5296_pkg.sv
  - logic/adc_mon_if.sv
  - logic/adc_dly_if.sv
  - logic/frame_monitor.sv
  - logic/wb_ads5296_regs.sv
  - logic/idelay_load_seq.sv
  - logic/ads5296_ctrl_top.sv
  - target: test
    files:
      - testbench/tb_ads5296_ctrl.sv
